//--- verilog/jtag_pkg.sv
// JTAG TAP definitions

package jtag_pkg;

    // JTAG pins, sampled in the system clock domain
    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
        logic trst;
    } jtag_in_t;

    localparam int INSTRUCTION_WIDTH = 4;

    // Instruction codes
    localparam logic [INSTRUCTION_WIDTH-1:0] INST_IDCODE  = 4'h1;
    localparam logic [INSTRUCTION_WIDTH-1:0] INST_CONTROL = 4'h2;
    localparam logic [INSTRUCTION_WIDTH-1:0] INST_STATUS  = 4'h3;
    localparam logic [INSTRUCTION_WIDTH-1:0] INST_BYPASS  = 4'hf;

    // Data register select
    typedef enum logic [1:0] {
        SEL_IDCODE,
        SEL_CONTROL,
        SEL_STATUS,
        SEL_BYPASS
    } dr_sel_t;

    // One-clk strobes from the TAP to the data registers
    typedef struct packed {
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } dr_ctrl_t;

endpackage

//--- verilog/debug_pkg.sv
// Debug system interface definitions

package debug_pkg;

    // Written by the debugger through the CONTROL register
    typedef struct packed {
        logic       halt;
        logic       single_step;
        logic [5:0] reserved;
        logic [7:0] target;
    } sys_control_t;

    // Read by the debugger through the STATUS register
    typedef struct packed {
        logic       halted;
        logic [6:0] reserved;
        logic [7:0] pc_low;
    } sys_status_t;

    localparam logic [31:0] IDCODE_VALUE = 32'h1A5B_0C1D;

endpackage

//--- verilog/jtag_tap_controller.sv
// JTAG TAP controller

`timescale 1ns/10ps

module jtag_tap_controller
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  jtag_pkg::jtag_in_t                        pins,
    input  logic                                      data_shift_val,
    output jtag_pkg::dr_ctrl_t                        dr_ctrl,
    output logic [jtag_pkg::INSTRUCTION_WIDTH-1:0]    instruction,
    output logic                                      tdo
);

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR_SCAN,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        PAUSE_DR,
        EXIT2_DR,
        UPDATE_DR,
        SELECT_IR_SCAN,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        PAUSE_IR,
        EXIT2_IR,
        UPDATE_IR
    } tap_state_t;

    tap_state_t state_ff;
    tap_state_t state_nxt;
    logic       last_tck;
    logic       tck_rise;
    logic       tck_fall;
    logic       advance;

    // TCK edges, seen by comparing with the sample one clk earlier
    assign tck_rise = pins.tck && !last_tck;
    assign tck_fall = !pins.tck && last_tck;

    // trst holds the machine in Test-Logic-Reset, so no strobes fire
    assign advance = tck_rise && !pins.trst;

    // Standard IEEE 1149.1 state transitions, taken on TCK rising edges
    always_comb
    begin
        state_nxt = state_ff;
        case (state_ff)
            TEST_LOGIC_RESET:
                state_nxt = pins.tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:
                state_nxt = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:
                state_nxt = pins.tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:
                state_nxt = pins.tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:
                state_nxt = pins.tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:
                state_nxt = pins.tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:
                state_nxt = pins.tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:
                state_nxt = pins.tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:
                state_nxt = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:
                state_nxt = pins.tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:
                state_nxt = pins.tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:
                state_nxt = pins.tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:
                state_nxt = pins.tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:
                state_nxt = pins.tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:
                state_nxt = pins.tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:
                state_nxt = pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:
                state_nxt = TEST_LOGIC_RESET;
        endcase
    end

    // Strobes are valid in the clk where the rising edge is detected
    assign dr_ctrl.capture_dr = advance && (state_ff == CAPTURE_DR);
    assign dr_ctrl.shift_dr   = advance && (state_ff == SHIFT_DR);
    assign dr_ctrl.update_dr  = advance && (state_ff == UPDATE_DR);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_ff    <= TEST_LOGIC_RESET;
            last_tck    <= 1'b0;
            instruction <= '0;
            tdo         <= 1'b0;
        end
        else
        begin
            last_tck <= pins.tck;

            // The instruction survives trst
            if (pins.trst)
            begin
                state_ff <= TEST_LOGIC_RESET;
            end
            else if (tck_rise)
            begin
                state_ff <= state_nxt;
                if (state_ff == SHIFT_IR)
                begin
                    instruction <= {pins.tdi,
                                    instruction[jtag_pkg::INSTRUCTION_WIDTH-1:1]};
                end
            end

            // TDO changes on the falling edge so the debugger samples it stable
            if (tck_fall)
            begin
                tdo <= (state_ff == SHIFT_IR) ? instruction[0] : data_shift_val;
            end
        end
    end

endmodule

//--- verilog/jtag_ir_decode.sv
// JTAG instruction decoder

`timescale 1ns/10ps

module jtag_ir_decode
(
    input  logic [jtag_pkg::INSTRUCTION_WIDTH-1:0] instruction,
    output jtag_pkg::dr_sel_t                      dr_sel
);

    // New instructions get their data register select here
    always_comb
    begin
        case (instruction)
            // Code 0 is the value after reset, so IDCODE is readable at once
            '0:
                dr_sel = jtag_pkg::SEL_IDCODE;
            jtag_pkg::INST_IDCODE:
                dr_sel = jtag_pkg::SEL_IDCODE;
            jtag_pkg::INST_CONTROL:
                dr_sel = jtag_pkg::SEL_CONTROL;
            jtag_pkg::INST_STATUS:
                dr_sel = jtag_pkg::SEL_STATUS;
            jtag_pkg::INST_BYPASS:
                dr_sel = jtag_pkg::SEL_BYPASS;
            // Unknown codes behave as BYPASS
            default:
                dr_sel = jtag_pkg::SEL_BYPASS;
        endcase
    end

endmodule

//--- verilog/jtag_data_reg.sv
// JTAG capture, shift and update register

`timescale 1ns/10ps

module jtag_data_reg
#(
    parameter type payload_t = logic [15:0]
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  logic     tdi,
    input  payload_t capture_val,
    output logic     shift_out,
    output payload_t update_val,
    output logic     updated
);

    localparam int WIDTH = $bits(payload_t);

    logic [WIDTH-1:0] shift_reg;

    // LSB leaves first on TDO
    assign shift_out = shift_reg[0];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_reg  <= '0;
            update_val <= '0;
            updated    <= 1'b0;
        end
        else
        begin
            updated <= update;
            if (capture)
                shift_reg <= capture_val;
            else if (shift)
                shift_reg <= {tdi, shift_reg[WIDTH-1:1]};
            if (update)
                update_val <= payload_t'(shift_reg);
        end
    end

endmodule

//--- verilog/jtag_data_path.sv
// JTAG data register path

`timescale 1ns/10ps

module jtag_data_path
(
    input  logic                   clk,
    input  logic                   reset,
    input  jtag_pkg::dr_ctrl_t     dr_ctrl,
    input  jtag_pkg::dr_sel_t      dr_sel,
    input  logic                   tdi,
    input  debug_pkg::sys_status_t sys_status,
    output logic                   data_shift_val,
    output debug_pkg::sys_control_t sys_control,
    output logic                   control_valid
);

    logic idcode_sel;
    logic control_sel;
    logic status_sel;
    logic bypass_sel;
    logic idcode_out;
    logic control_out;
    logic status_out;
    logic bypass_reg;

    assign idcode_sel  = (dr_sel == jtag_pkg::SEL_IDCODE);
    assign control_sel = (dr_sel == jtag_pkg::SEL_CONTROL);
    assign status_sel  = (dr_sel == jtag_pkg::SEL_STATUS);
    assign bypass_sel  = (dr_sel == jtag_pkg::SEL_BYPASS);

    // Read only, never updated
    jtag_data_reg #(.payload_t(logic [31:0])) idcode_reg (
        .clk        (clk),
        .reset      (reset),
        .capture    (dr_ctrl.capture_dr && idcode_sel),
        .shift      (dr_ctrl.shift_dr && idcode_sel),
        .update     (1'b0),
        .tdi        (tdi),
        .capture_val(debug_pkg::IDCODE_VALUE),
        .shift_out  (idcode_out),
        .update_val (),
        .updated    ()
    );

    // Captures its own output so a scan reads back the last write
    jtag_data_reg #(.payload_t(debug_pkg::sys_control_t)) control_reg (
        .clk        (clk),
        .reset      (reset),
        .capture    (dr_ctrl.capture_dr && control_sel),
        .shift      (dr_ctrl.shift_dr && control_sel),
        .update     (dr_ctrl.update_dr && control_sel),
        .tdi        (tdi),
        .capture_val(sys_control),
        .shift_out  (control_out),
        .update_val (sys_control),
        .updated    (control_valid)
    );

    jtag_data_reg #(.payload_t(debug_pkg::sys_status_t)) status_reg (
        .clk        (clk),
        .reset      (reset),
        .capture    (dr_ctrl.capture_dr && status_sel),
        .shift      (dr_ctrl.shift_dr && status_sel),
        .update     (1'b0),
        .tdi        (tdi),
        .capture_val(sys_status),
        .shift_out  (status_out),
        .update_val (),
        .updated    ()
    );

    // One-bit BYPASS register captures 0
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bypass_reg <= 1'b0;
        else if (dr_ctrl.capture_dr && bypass_sel)
            bypass_reg <= 1'b0;
        else if (dr_ctrl.shift_dr && bypass_sel)
            bypass_reg <= tdi;
    end

    always_comb
    begin
        case (dr_sel)
            jtag_pkg::SEL_IDCODE:  data_shift_val = idcode_out;
            jtag_pkg::SEL_CONTROL: data_shift_val = control_out;
            jtag_pkg::SEL_STATUS:  data_shift_val = status_out;
            default:               data_shift_val = bypass_reg;
        endcase
    end

endmodule

//--- verilog/jtag_debug_top.sv
// JTAG debug access port

`timescale 1ns/10ps

module jtag_debug_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  jtag_pkg::jtag_in_t      jtag_pins,
    output logic                    tdo,
    input  debug_pkg::sys_status_t  sys_status,
    output debug_pkg::sys_control_t sys_control,
    output logic                    control_valid
);

    jtag_pkg::dr_ctrl_t                     dr_ctrl;
    jtag_pkg::dr_sel_t                      dr_sel;
    logic [jtag_pkg::INSTRUCTION_WIDTH-1:0] instruction;
    logic                                   data_shift_val;

    jtag_tap_controller tap_inst (
        .clk           (clk),
        .reset         (reset),
        .pins          (jtag_pins),
        .data_shift_val(data_shift_val),
        .dr_ctrl       (dr_ctrl),
        .instruction   (instruction),
        .tdo           (tdo)
    );

    jtag_ir_decode decode_inst (
        .instruction(instruction),
        .dr_sel     (dr_sel)
    );

    jtag_data_path data_path_inst (
        .clk           (clk),
        .reset         (reset),
        .dr_ctrl       (dr_ctrl),
        .dr_sel        (dr_sel),
        .tdi           (jtag_pins.tdi),
        .sys_status    (sys_status),
        .data_shift_val(data_shift_val),
        .sys_control   (sys_control),
        .control_valid (control_valid)
    );

endmodule

//--- verif/jtag_clk_gen.sv
// Clock and reset generator

`timescale 1ns/10ps

module jtag_clk_gen
#(
    parameter int PERIOD = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        // Three rising edges under reset, released on a falling edge
        repeat (3) @(negedge clk);
        reset = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

//--- verif/jtag_debug_chk.sv
// TAP output assertions

`timescale 1ns/10ps

module jtag_debug_chk
(
    input logic               clk,
    input logic               reset,
    input jtag_pkg::dr_ctrl_t dr_ctrl,
    input logic               tck_fall,
    input logic               tdo
);

    int failures = 0;

    // Capture, shift and update never overlap
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0(dr_ctrl))
    else
    begin
        $error("more than one DR strobe is active in the same clk");
        failures++;
    end

    strobes_idle_in_reset: assert property (@(posedge clk) reset |-> (dr_ctrl == '0))
    else
    begin
        $error("a DR strobe is active during reset");
        failures++;
    end

    // TDO moves only in the clk after a falling TCK edge
    tdo_after_fall: assert property (@(posedge clk) disable iff (reset)
        $changed(tdo) |-> $past(tck_fall))
    else
    begin
        $error("tdo changed without a falling TCK edge before it");
        failures++;
    end

endmodule

bind jtag_tap_controller jtag_debug_chk chk_inst (
    .clk     (clk),
    .reset   (reset),
    .dr_ctrl (dr_ctrl),
    .tck_fall(tck_fall),
    .tdo     (tdo)
);

//--- verif/jtag_debug_tb.sv
// JTAG debug port testbench

`timescale 1ns/10ps

module jtag_debug_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int MAX_VECTORS = 32;
    localparam int OP_END      = 0;
    localparam int OP_IR       = 1;
    localparam int OP_DR       = 2;
    localparam int OP_CONTROL  = 3;
    localparam int OP_STATUS   = 4;
    localparam int OP_TRST     = 5;

    logic                    clk;
    logic                    reset;
    jtag_pkg::jtag_in_t      jtag_pins;
    logic                    tdo;
    debug_pkg::sys_status_t  sys_status;
    debug_pkg::sys_control_t sys_control;
    logic                    control_valid;

    // Each vector is four words of operation, value, length and expected
    logic [31:0] vectors [0:4*MAX_VECTORS-1];
    integer      seed = 32'h67c3991e;
    int          num_vectors = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          valid_cycles = 0;
    logic [15:0] last_control = '0;

    jtag_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen_inst (
        .clk  (clk),
        .reset(reset)
    );

    jtag_debug_top jtag_debug_top_inst (
        .clk          (clk),
        .reset        (reset),
        .jtag_pins    (jtag_pins),
        .tdo          (tdo),
        .sys_status   (sys_status),
        .sys_control  (sys_control),
        .control_valid(control_valid)
    );

    // Counts the clks in which control_valid is high
    always @(negedge clk)
    begin
        if (control_valid)
            valid_cycles = valid_cycles + 1;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERR time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // One TCK period with tdo taken just before the rising edge
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo_bit);
        jtag_pins.tck = 1'b0;
        jtag_pins.tms = tms;
        jtag_pins.tdi = tdi;
        repeat (4) @(negedge clk);
        tdo_bit = tdo;
        jtag_pins.tck = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    // Full IR or DR scan from Run-Test-Idle and back with the LSB first
    task automatic scan(input logic ir, input logic [31:0] value, input int length,
                        input logic new_status, output logic [31:0] shifted_out);
        logic unused_bit;
        logic bit_out;
        shifted_out = '0;
        tck_cycle(1'b1, 1'b0, unused_bit);
        if (ir)
            tck_cycle(1'b1, 1'b0, unused_bit);
        tck_cycle(1'b0, 1'b0, unused_bit);
        tck_cycle(1'b0, 1'b0, unused_bit);
        // Capture is done, so the system may move on
        if (new_status)
            sys_status = 16'($random(seed));
        for (int i = 0; i < length; i++)
        begin
            tck_cycle(i == length - 1, value[i], bit_out);
            shifted_out[i] = bit_out;
        end
        tck_cycle(1'b1, 1'b0, unused_bit);
        tck_cycle(1'b0, 1'b0, unused_bit);
    endtask

    initial
    begin
        logic [31:0] op;
        logic [31:0] value;
        logic [31:0] length;
        logic [31:0] expected;
        logic [31:0] got;
        logic        unused_bit;
        int          valid_before;

        jtag_pins  = '0;
        sys_status = '0;
        for (int i = 0; i < 4 * MAX_VECTORS; i++)
            vectors[i] = '0;
        $readmemh("verif/jtag_input.dat", vectors);
        while (num_vectors < MAX_VECTORS && vectors[4 * num_vectors] != OP_END)
            num_vectors++;
        assert (num_vectors > 0)
        else
        begin
            $display("No test vectors could be read from verif/jtag_input.dat");
            other_errors++;
        end

        @(negedge reset);
        @(negedge clk);
        // Five TMS highs reach Test-Logic-Reset and one low reaches Run-Test-Idle
        repeat (5) tck_cycle(1'b1, 1'b0, unused_bit);
        tck_cycle(1'b0, 1'b0, unused_bit);

        for (int n = 0; n < num_vectors; n++)
        begin
            op       = vectors[4 * n];
            value    = vectors[4 * n + 1];
            length   = vectors[4 * n + 2];
            expected = vectors[4 * n + 3];
            case (op)
                OP_IR:
                begin
                    scan(1'b1, value, int'(length), 1'b0, got);
                    compare_value("ir_scan_out", expected, got);
                end
                OP_DR:
                begin
                    scan(1'b0, value, int'(length), 1'b0, got);
                    compare_value("dr_scan_out", expected, got);
                end
                OP_CONTROL:
                begin
                    value = $random(seed) & 32'h0000_ffff;
                    valid_before = valid_cycles;
                    scan(1'b0, value, 16, 1'b0, got);
                    compare_value("control_readback", {16'h0, last_control}, got);
                    compare_value("sys_control", value, {16'h0, sys_control});
                    compare_value("control_valid_cycles", 1, valid_cycles - valid_before);
                    last_control = value[15:0];
                end
                OP_STATUS:
                begin
                    sys_status = 16'($random(seed));
                    value = {16'h0, sys_status};
                    scan(1'b0, 32'h0, 16, 1'b1, got);
                    compare_value("status_out", value, got);
                end
                OP_TRST:
                begin
                    jtag_pins.trst = 1'b1;
                    tck_cycle(1'b1, 1'b0, unused_bit);
                    jtag_pins.trst = 1'b0;
                    tck_cycle(1'b0, 1'b0, unused_bit);
                end
                default:
                begin
                    $display("Unknown operation %0d in test vector %0d", op, n);
                    other_errors++;
                end
            endcase
        end

        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, jtag_debug_top_inst.tap_inst.chk_inst.failures);
        if (value_errors + other_errors + jtag_debug_top_inst.tap_inst.chk_inst.failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Each vector gets 60 TCK periods of 8 clk plus room for reset and the TAP reset walk
    initial
    begin
        wait (num_vectors > 0);
        #(num_vectors * 60 * 8 * CLK_PERIOD + 2000);
        $display("Timeout: the run did not finish in the time allowed for %0d vectors",
                 num_vectors);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verif/jtag_input.dat
// op value length expected, all hex
// op 1 IR scan, 2 DR scan, 3 CONTROL write, 4 STATUS read, 5 TRST pulse, 0 end
2 00000000 20 1a5b0c1d
1 00000002 04 00000000
3 00000000 10 00000000
3 00000000 10 00000000
1 00000003 04 00000002
4 00000000 10 00000000
1 0000000f 04 00000003
2 000000a5 08 0000004a
1 00000007 04 0000000f
2 0000003c 08 00000078
5 00000000 00 00000000
2 000000c3 08 00000086
1 00000001 04 00000007
2 00000000 20 1a5b0c1d
0 00000000 00 00000000

//--- list.f
verilog/jtag_pkg.sv
verilog/debug_pkg.sv
verilog/jtag_tap_controller.sv
verilog/jtag_ir_decode.sv
verilog/jtag_data_reg.sv
verilog/jtag_data_path.sv
verilog/jtag_debug_top.sv
verif/jtag_clk_gen.sv
verif/jtag_debug_chk.sv
verif/jtag_debug_tb.sv
